//--- Bender.yml
package:
  name: wb_scratch_mem

sources:
  - include_dirs:
      - common
    files:
      - common/wbmem_pkg.sv
      - dp_ram/dp_ram.sv
      - dp_ram/wb_dp_ram_ctrl.sv
      - hdl/wb_arbiter.sv
      - hdl/dma_copy.sv
      - hdl/mem_subsys_top.sv
      - target: test
        files:
          - tb/tb_clk_gen.sv
          - tb/tb_mem_subsys.sv

//--- build.f
+incdir+common
common/wbmem_pkg.sv
dp_ram/dp_ram.sv
dp_ram/wb_dp_ram_ctrl.sv
hdl/wb_arbiter.sv
hdl/dma_copy.sv
hdl/mem_subsys_top.sv
tb/tb_clk_gen.sv
tb/tb_mem_subsys.sv

//--- common/wbmem_params.svh
`ifndef WBMEM_PARAMS_SVH
`define WBMEM_PARAMS_SVH

// Word address width, 1024 words
`define WBMEM_ADDR_WIDTH 10

// Wishbone data word
`define WBMEM_DATA_WIDTH 32

// One select bit per byte
`define WBMEM_SEL_WIDTH 4

`endif

//--- common/wbmem_pkg.sv
`default_nettype none

package wbmem_pkg;

    // Copy engine FSM
    typedef enum logic [1:0] {
        DMA_IDLE  = 2'd0, // Waiting for start
        DMA_READ  = 2'd1, // Source word read in flight
        DMA_WRITE = 2'd2, // Destination word write in flight
        DMA_DONE  = 2'd3  // Block finished, done pulse next
    } dma_state_e;

    // Who holds RAM port B
    typedef enum logic {
        OWN_HOST = 1'b0, // External host B
        OWN_DMA  = 1'b1  // Copy engine
    } arb_owner_e;

endpackage

`default_nettype wire

//--- dp_ram/dp_ram.sv
`timescale 1ns/1ns
`default_nettype none
`include "wbmem_params.svh"

module dp_ram #(
    parameter int ADDR_WIDTH = 10 // Word address bits
) (
    input  wire                          clk,
    input  wire                          a_en_i,
    input  wire [`WBMEM_SEL_WIDTH-1:0]   a_we_i,  // Per byte write enable
    input  wire [ADDR_WIDTH-1:0]         a_adr_i,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  a_dat_i,
    output logic [`WBMEM_DATA_WIDTH-1:0] a_dat_o,
    input  wire                          b_en_i,
    input  wire [`WBMEM_SEL_WIDTH-1:0]   b_we_i,
    input  wire [ADDR_WIDTH-1:0]         b_adr_i,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  b_dat_i,
    output logic [`WBMEM_DATA_WIDTH-1:0] b_dat_o
);

    logic [`WBMEM_DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];
    logic [`WBMEM_DATA_WIDTH-1:0] a_merge; // Old word with new bytes laid over
    logic [`WBMEM_DATA_WIDTH-1:0] b_merge;

    // Write-first view of each port
    always_comb begin
        a_merge = mem[a_adr_i];
        b_merge = mem[b_adr_i];
        for (int i = 0; i < `WBMEM_SEL_WIDTH; i++) begin
            if (a_we_i[i]) a_merge[8*i +: 8] = a_dat_i[8*i +: 8];
            if (b_we_i[i]) b_merge[8*i +: 8] = b_dat_i[8*i +: 8];
        end
    end

    // Both ports in one process, so port B wins a same-word clash
    always_ff @(posedge clk) begin
        if (a_en_i) begin
            if (|a_we_i) mem[a_adr_i] <= a_merge;
            a_dat_o <= a_merge; // Registered read, one cycle
        end
        if (b_en_i) begin
            if (|b_we_i) mem[b_adr_i] <= b_merge;
            b_dat_o <= b_merge;
        end
    end

endmodule

`default_nettype wire

//--- dp_ram/wb_dp_ram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "wbmem_params.svh"

module wb_dp_ram_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    // Port A
    input  wire                          a_cyc_i,
    input  wire                          a_stb_i,
    input  wire                          a_we_i,
    input  wire [`WBMEM_SEL_WIDTH-1:0]   a_sel_i,
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  a_adr_i,  // Word address
    input  wire [`WBMEM_DATA_WIDTH-1:0]  a_dat_i,
    output wire [`WBMEM_DATA_WIDTH-1:0]  a_dat_o,
    output wire                          a_ack_o,
    output wire                          a_stall_o,
    // Port B
    input  wire                          b_cyc_i,
    input  wire                          b_stb_i,
    input  wire                          b_we_i,
    input  wire [`WBMEM_SEL_WIDTH-1:0]   b_sel_i,
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  b_adr_i,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  b_dat_i,
    output wire [`WBMEM_DATA_WIDTH-1:0]  b_dat_o,
    output wire                          b_ack_o,
    output wire                          b_stall_o
);

    logic                        a_valid, b_valid; // Request taken this cycle
    logic [`WBMEM_SEL_WIDTH-1:0] a_ram_we, b_ram_we;
    logic                        a_ack_q, b_ack_q;

    // RAM takes every request at once, no back-pressure
    assign a_stall_o = 1'b0;
    assign b_stall_o = 1'b0;

    assign a_valid  = a_cyc_i & a_stb_i & ~a_stall_o;
    assign b_valid  = b_cyc_i & b_stb_i & ~b_stall_o;
    assign a_ram_we = {`WBMEM_SEL_WIDTH{a_valid & a_we_i}} & a_sel_i; // Byte writes
    assign b_ram_we = {`WBMEM_SEL_WIDTH{b_valid & b_we_i}} & b_sel_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_ack_q <= 1'b0;
            b_ack_q <= 1'b0;
        end else begin
            a_ack_q <= a_valid; // Ack one cycle after accept
            b_ack_q <= b_valid;
        end
    end

    // Abandoned cycle loses its ack
    assign a_ack_o = a_ack_q & a_cyc_i;
    assign b_ack_o = b_ack_q & b_cyc_i;

    dp_ram #(
        .ADDR_WIDTH(`WBMEM_ADDR_WIDTH)
    ) u_ram (
        .clk     (clk),
        .a_en_i  (a_valid),
        .a_we_i  (a_ram_we),
        .a_adr_i (a_adr_i),
        .a_dat_i (a_dat_i),
        .a_dat_o (a_dat_o),
        .b_en_i  (b_valid),
        .b_we_i  (b_ram_we),
        .b_adr_i (b_adr_i),
        .b_dat_i (b_dat_i),
        .b_dat_o (b_dat_o)
    );

endmodule

`default_nettype wire

//--- hdl/dma_copy.sv
`timescale 1ns/1ns
`default_nettype none
`include "wbmem_params.svh"

module dma_copy (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start_i,  // One cycle pulse
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  src_i,    // First source word
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  dst_i,    // First destination word
    input  wire [`WBMEM_ADDR_WIDTH:0]    len_i,    // Word count, may be 0
    output wire                          busy_o,
    output wire                          done_o,
    // Wishbone master
    output wire                          m_cyc_o,
    output wire                          m_stb_o,
    output wire                          m_we_o,
    output wire [`WBMEM_SEL_WIDTH-1:0]   m_sel_o,
    output wire [`WBMEM_ADDR_WIDTH-1:0]  m_adr_o,
    output wire [`WBMEM_DATA_WIDTH-1:0]  m_dat_o,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  m_dat_i,
    input  wire                          m_ack_i,
    input  wire                          m_stall_i
);

    wbmem_pkg::dma_state_e        state_q;
    logic                         stb_q;    // Request not yet taken
    logic                         done_q;
    logic [`WBMEM_ADDR_WIDTH-1:0] src_q, dst_q;
    logic [`WBMEM_ADDR_WIDTH:0]   remain_q; // Words still to copy
    logic [`WBMEM_DATA_WIDTH-1:0] data_q;   // Word in transit

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= wbmem_pkg::DMA_IDLE;
            stb_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                wbmem_pkg::DMA_IDLE: begin
                    if (start_i) begin
                        // Empty block skips the bus
                        state_q <= (len_i == '0) ? wbmem_pkg::DMA_DONE : wbmem_pkg::DMA_READ;
                        stb_q   <= (len_i != '0);
                    end
                end
                wbmem_pkg::DMA_READ: begin
                    if (stb_q && !m_stall_i) stb_q <= 1'b0;
                    if (m_ack_i) begin
                        state_q <= wbmem_pkg::DMA_WRITE;
                        stb_q   <= 1'b1;
                    end
                end
                wbmem_pkg::DMA_WRITE: begin
                    if (stb_q && !m_stall_i) stb_q <= 1'b0;
                    if (m_ack_i) begin
                        if (remain_q == 1) begin
                            state_q <= wbmem_pkg::DMA_DONE; // Last word written
                        end else begin
                            state_q <= wbmem_pkg::DMA_READ;
                            stb_q   <= 1'b1;
                        end
                    end
                end
                wbmem_pkg::DMA_DONE: begin
                    state_q <= wbmem_pkg::DMA_IDLE;
                    done_q  <= 1'b1;
                end
                default: state_q <= wbmem_pkg::DMA_IDLE;
            endcase
        end
    end

    // Counters and read data
    always_ff @(posedge clk) begin
        if (state_q == wbmem_pkg::DMA_IDLE && start_i) begin
            src_q    <= src_i;
            dst_q    <= dst_i;
            remain_q <= len_i;
        end
        if (state_q == wbmem_pkg::DMA_READ && m_ack_i) data_q <= m_dat_i;
        if (state_q == wbmem_pkg::DMA_WRITE && m_ack_i) begin
            src_q    <= src_q + 1'b1;
            dst_q    <= dst_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

    // cyc spans the whole block so the arbiter cannot switch
    assign m_cyc_o = (state_q == wbmem_pkg::DMA_READ) || (state_q == wbmem_pkg::DMA_WRITE);
    assign m_stb_o = stb_q;
    assign m_we_o  = (state_q == wbmem_pkg::DMA_WRITE);
    assign m_sel_o = '1; // Whole words only
    assign m_adr_o = m_we_o ? dst_q : src_q;
    assign m_dat_o = data_q;

    assign busy_o = (state_q != wbmem_pkg::DMA_IDLE);
    assign done_o = done_q;

endmodule

`default_nettype wire

//--- hdl/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "wbmem_params.svh"

module mem_subsys_top (
    input  wire                          clk,
    input  wire                          rst,
    // Host A, direct to RAM port A
    input  wire                          a_cyc_i,
    input  wire                          a_stb_i,
    input  wire                          a_we_i,
    input  wire [`WBMEM_SEL_WIDTH-1:0]   a_sel_i,
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  a_adr_i,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  a_dat_i,
    output wire [`WBMEM_DATA_WIDTH-1:0]  a_dat_o,
    output wire                          a_ack_o,
    output wire                          a_stall_o,
    // Host B, shares port B with the DMA
    input  wire                          b_cyc_i,
    input  wire                          b_stb_i,
    input  wire                          b_we_i,
    input  wire [`WBMEM_SEL_WIDTH-1:0]   b_sel_i,
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  b_adr_i,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  b_dat_i,
    output wire [`WBMEM_DATA_WIDTH-1:0]  b_dat_o,
    output wire                          b_ack_o,
    output wire                          b_stall_o,
    // Copy engine control
    input  wire                          dma_start_i,
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  dma_src_i,
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  dma_dst_i,
    input  wire [`WBMEM_ADDR_WIDTH:0]    dma_len_i,
    output wire                          dma_busy_o,
    output wire                          dma_done_o,
    output wbmem_pkg::arb_owner_e        arb_owner_o  // Debug view of port B owner
);

    // DMA master bus
    wire                         d_cyc, d_stb, d_we, d_ack, d_stall;
    wire [`WBMEM_SEL_WIDTH-1:0]  d_sel;
    wire [`WBMEM_ADDR_WIDTH-1:0] d_adr;
    wire [`WBMEM_DATA_WIDTH-1:0] d_wdat, d_rdat;
    // Arbiter to RAM port B
    wire                         s_cyc, s_stb, s_we, s_ack, s_stall;
    wire [`WBMEM_SEL_WIDTH-1:0]  s_sel;
    wire [`WBMEM_ADDR_WIDTH-1:0] s_adr;
    wire [`WBMEM_DATA_WIDTH-1:0] s_wdat, s_rdat;

    dma_copy u_dma (
        .clk(clk), .rst(rst),
        .start_i(dma_start_i), .src_i(dma_src_i), .dst_i(dma_dst_i), .len_i(dma_len_i),
        .busy_o(dma_busy_o), .done_o(dma_done_o),
        .m_cyc_o(d_cyc), .m_stb_o(d_stb), .m_we_o(d_we), .m_sel_o(d_sel),
        .m_adr_o(d_adr), .m_dat_o(d_wdat), .m_dat_i(d_rdat),
        .m_ack_i(d_ack), .m_stall_i(d_stall)
    );

    wb_arbiter u_arb (
        .clk(clk), .rst(rst),
        .h_cyc_i(b_cyc_i), .h_stb_i(b_stb_i), .h_we_i(b_we_i), .h_sel_i(b_sel_i),
        .h_adr_i(b_adr_i), .h_dat_i(b_dat_i), .h_dat_o(b_dat_o),
        .h_ack_o(b_ack_o), .h_stall_o(b_stall_o),
        .d_cyc_i(d_cyc), .d_stb_i(d_stb), .d_we_i(d_we), .d_sel_i(d_sel),
        .d_adr_i(d_adr), .d_dat_i(d_wdat), .d_dat_o(d_rdat),
        .d_ack_o(d_ack), .d_stall_o(d_stall),
        .s_cyc_o(s_cyc), .s_stb_o(s_stb), .s_we_o(s_we), .s_sel_o(s_sel),
        .s_adr_o(s_adr), .s_dat_o(s_wdat), .s_dat_i(s_rdat),
        .s_ack_i(s_ack), .s_stall_i(s_stall),
        .owner_o(arb_owner_o)
    );

    wb_dp_ram_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .a_cyc_i(a_cyc_i), .a_stb_i(a_stb_i), .a_we_i(a_we_i), .a_sel_i(a_sel_i),
        .a_adr_i(a_adr_i), .a_dat_i(a_dat_i), .a_dat_o(a_dat_o),
        .a_ack_o(a_ack_o), .a_stall_o(a_stall_o),
        .b_cyc_i(s_cyc), .b_stb_i(s_stb), .b_we_i(s_we), .b_sel_i(s_sel),
        .b_adr_i(s_adr), .b_dat_i(s_wdat), .b_dat_o(s_rdat),
        .b_ack_o(s_ack), .b_stall_o(s_stall)
    );

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "wbmem_params.svh"

module wb_arbiter (
    input  wire                          clk,
    input  wire                          rst,
    // Host B master
    input  wire                          h_cyc_i,
    input  wire                          h_stb_i,
    input  wire                          h_we_i,
    input  wire [`WBMEM_SEL_WIDTH-1:0]   h_sel_i,
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  h_adr_i,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  h_dat_i,
    output wire [`WBMEM_DATA_WIDTH-1:0]  h_dat_o,
    output wire                          h_ack_o,
    output wire                          h_stall_o,
    // DMA master
    input  wire                          d_cyc_i,
    input  wire                          d_stb_i,
    input  wire                          d_we_i,
    input  wire [`WBMEM_SEL_WIDTH-1:0]   d_sel_i,
    input  wire [`WBMEM_ADDR_WIDTH-1:0]  d_adr_i,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  d_dat_i,
    output wire [`WBMEM_DATA_WIDTH-1:0]  d_dat_o,
    output wire                          d_ack_o,
    output wire                          d_stall_o,
    // Toward RAM port B
    output wire                          s_cyc_o,
    output wire                          s_stb_o,
    output wire                          s_we_o,
    output wire [`WBMEM_SEL_WIDTH-1:0]   s_sel_o,
    output wire [`WBMEM_ADDR_WIDTH-1:0]  s_adr_o,
    output wire [`WBMEM_DATA_WIDTH-1:0]  s_dat_o,
    input  wire [`WBMEM_DATA_WIDTH-1:0]  s_dat_i,
    input  wire                          s_ack_i,
    input  wire                          s_stall_i,
    output wbmem_pkg::arb_owner_e        owner_o
);

    wbmem_pkg::arb_owner_e owner_q; // Last owner, for round robin
    wbmem_pkg::arb_owner_e grant;
    logic                  busy_q;  // Port B held by owner_q
    logic                  owner_cyc;
    logic                  h_sel, d_sel;

    always_comb begin
        owner_cyc = (owner_q == wbmem_pkg::OWN_HOST) ? h_cyc_i : d_cyc_i;
        if (busy_q && owner_cyc) grant = owner_q;       // Owner keeps the port
        else if (h_cyc_i && d_cyc_i)                    // Both want it, other side wins
            grant = (owner_q == wbmem_pkg::OWN_HOST) ? wbmem_pkg::OWN_DMA : wbmem_pkg::OWN_HOST;
        else if (d_cyc_i) grant = wbmem_pkg::OWN_DMA;
        else grant = wbmem_pkg::OWN_HOST;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= wbmem_pkg::OWN_HOST;
            busy_q  <= 1'b0;
        end else begin
            busy_q <= h_cyc_i | d_cyc_i; // Granted side has cyc up
            if (h_cyc_i | d_cyc_i) owner_q <= grant;
        end
    end

    assign h_sel = (grant == wbmem_pkg::OWN_HOST);
    assign d_sel = ~h_sel;

    // Granted request goes straight through, no added cycle
    assign s_cyc_o = h_sel ? h_cyc_i : d_cyc_i;
    assign s_stb_o = h_sel ? h_stb_i : d_stb_i;
    assign s_we_o  = h_sel ? h_we_i  : d_we_i;
    assign s_sel_o = h_sel ? h_sel_i : d_sel_i;
    assign s_adr_o = h_sel ? h_adr_i : d_adr_i;
    assign s_dat_o = h_sel ? h_dat_i : d_dat_i;

    // Loser waits on stall, sees no ack or data
    assign h_ack_o   = h_sel & s_ack_i;
    assign d_ack_o   = d_sel & s_ack_i;
    assign h_stall_o = h_sel ? s_stall_i : h_cyc_i;
    assign d_stall_o = d_sel ? s_stall_i : d_cyc_i;
    assign h_dat_o   = h_sel ? s_dat_i : '0;
    assign d_dat_o   = d_sel ? s_dat_i : '0;

    assign owner_o = grant;

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 4 ns period
    end

    // Reset held for 16 rising edges, released off the edge
    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none
`include "wbmem_params.svh"

module tb_mem_subsys;

    localparam int TIMEOUT = 500; // Cycles per wait
    localparam int DEPTH   = 2**`WBMEM_ADDR_WIDTH;

    logic clk, rst;
    logic a_cyc, a_stb, a_we, a_ack, a_stall;
    logic b_cyc, b_stb, b_we, b_ack, b_stall;
    logic [`WBMEM_SEL_WIDTH-1:0]  a_sel, b_sel;
    logic [`WBMEM_ADDR_WIDTH-1:0] a_adr, b_adr, dma_src, dma_dst;
    logic [`WBMEM_DATA_WIDTH-1:0] a_wdat, a_rdat, b_wdat, b_rdat;
    logic [`WBMEM_ADDR_WIDTH:0]   dma_len;
    logic dma_start, dma_busy, dma_done;
    wbmem_pkg::arb_owner_e arb_owner;

    logic [`WBMEM_DATA_WIDTH-1:0] model [DEPTH]; // Expected RAM contents
    logic [31:0] lfsr = 32'hbda4;
    int errors = 0;
    int timeouts = 0;
    int done_count = 0; // dma_done_o pulses seen

    tb_clk_gen u_clk (.clk_o(clk), .rst_o(rst));

    mem_subsys_top dut0 (
        .clk(clk), .rst(rst),
        .a_cyc_i(a_cyc), .a_stb_i(a_stb), .a_we_i(a_we), .a_sel_i(a_sel),
        .a_adr_i(a_adr), .a_dat_i(a_wdat), .a_dat_o(a_rdat),
        .a_ack_o(a_ack), .a_stall_o(a_stall),
        .b_cyc_i(b_cyc), .b_stb_i(b_stb), .b_we_i(b_we), .b_sel_i(b_sel),
        .b_adr_i(b_adr), .b_dat_i(b_wdat), .b_dat_o(b_rdat),
        .b_ack_o(b_ack), .b_stall_o(b_stall),
        .dma_start_i(dma_start), .dma_src_i(dma_src), .dma_dst_i(dma_dst),
        .dma_len_i(dma_len), .dma_busy_o(dma_busy), .dma_done_o(dma_done),
        .arb_owner_o(arb_owner)
    );

    always @(posedge clk) if (dma_done) done_count++;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]}; // One step per bit
        end
        return r;
    endfunction

    // Byte-select merge of a write into the old word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, new_w,
                                                input logic [3:0] sel);
        for (int i = 0; i < 4; i++) if (sel[i]) old[8*i +: 8] = new_w[8*i +: 8];
        return old;
    endfunction

    function automatic logic [31:0] fill_word(input logic [`WBMEM_ADDR_WIDTH-1:0] adr);
        return {~adr[5:0], adr, 6'h2a, adr};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout after %0d cycles while waiting for %s", TIMEOUT, what);
        timeouts++;
    endtask

    // Single access on port A, ack must follow in one cycle
    task automatic a_access(input logic we, input logic [3:0] sel,
                            input logic [9:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
        int n;
        a_cyc  = 1'b1;
        a_stb  = 1'b1;
        a_we   = we;
        a_sel  = sel;
        a_adr  = adr;
        a_wdat = dat;
        @(posedge clk);
        check_val("a_stall_o", 0, a_stall);
        #1 a_stb = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!a_ack && n < TIMEOUT);
        if (!a_ack) report_timeout("ack on port A");
        check_val("a_ack_latency", 1, n);
        rdat = a_rdat;
        #1 a_cyc = 1'b0;
    endtask

    // Single access on port B, may be stalled by the arbiter
    task automatic b_access(input logic we, input logic [3:0] sel,
                            input logic [9:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat, output int stalls);
        int n;
        b_cyc  = 1'b1;
        b_stb  = 1'b1;
        b_we   = we;
        b_sel  = sel;
        b_adr  = adr;
        b_wdat = dat;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (b_stall && n < TIMEOUT);
        if (b_stall) report_timeout("port B to leave stall");
        stalls = n - 1;
        #1 b_stb = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!b_ack && n < TIMEOUT);
        if (!b_ack) report_timeout("ack on port B");
        check_val("arb_owner_o", wbmem_pkg::OWN_HOST, arb_owner);
        rdat = b_rdat;
        #1 b_cyc = 1'b0;
    endtask

    task automatic launch_copy(input logic [9:0] src, dst, input logic [10:0] len);
        dma_src   = src;
        dma_dst   = dst;
        dma_len   = len;
        dma_start = 1'b1;
        @(posedge clk);
        #1 dma_start = 1'b0;
        check_val("dma_busy_o", 1, dma_busy);
    endtask

    task automatic wait_copy(input int expected, output int cycles);
        int n;
        n = 0;
        while (done_count < expected && n < TIMEOUT) begin
            @(posedge clk);
            #1 n++;
        end
        if (done_count < expected) report_timeout("DMA done");
        check_val("dma_done_count", expected, done_count); // Exactly one pulse
        check_val("dma_busy_o", 0, dma_busy);
        cycles = n;
    endtask

    // Port A readback of the model over a block
    task automatic check_block(input logic [9:0] base, input int len);
        logic [31:0] rd;
        logic [9:0] adr;
        for (int i = 0; i < len; i++) begin
            adr = base + i[9:0];
            a_access(1'b0, 4'hf, adr, 32'h0, rd);
            check_val("a_dat_o", model[adr], rd);
        end
    endtask

    initial begin
        logic [31:0] rd, dat;
        logic [9:0]  adr, src, dst;
        logic [9:0]  addrs [4];
        logic [3:0]  sel;
        logic [10:0] len;
        int n, stalls, cycles, copies;
        a_cyc     = 0;
        a_stb     = 0;
        a_we      = 0;
        a_sel     = '0;
        a_adr     = '0;
        a_wdat    = '0;
        b_cyc     = 0;
        b_stb     = 0;
        b_we      = 0;
        b_sel     = '0;
        b_adr     = '0;
        b_wdat    = '0;
        dma_start = 0;
        dma_src   = '0;
        dma_dst   = '0;
        dma_len   = '0;
        copies = 0;
        n = 0;
        while (rst !== 1'b0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) report_timeout("reset release");
        @(posedge clk);
        #1;
        // Outputs idle after reset
        check_val("a_ack_o", 0, a_ack);
        check_val("b_ack_o", 0, b_ack);
        check_val("dma_busy_o", 0, dma_busy);
        check_val("dma_done_o", 0, dma_done);
        check_val("arb_owner_o", wbmem_pkg::OWN_HOST, arb_owner);

        // Fill whole RAM over port A, one write per cycle
        a_cyc = 1;
        a_stb = 1;
        a_we  = 1;
        a_sel = 4'hf;
        for (int i = 0; i < DEPTH; i++) begin
            a_adr = i[9:0];
            a_wdat = fill_word(i[9:0]);
            model[i] = fill_word(i[9:0]);
            @(posedge clk);
            #1;
        end
        a_stb = 0;
        @(posedge clk);
        #1 a_cyc = 0;
        a_we = 0;

        // 1. Port A write with random sel, then read back
        repeat (20) begin
            adr = rand_bits(10);
            dat = rand_bits(32);
            sel = rand_bits(4);
            a_access(1'b1, sel, adr, dat, rd);
            model[adr] = merge_bytes(model[adr], dat, sel);
            a_access(1'b0, 4'hf, adr, 32'h0, rd);
            check_val("a_dat_o", model[adr], rd);
        end

        // 2. Four pipelined reads, acks on consecutive cycles
        for (int i = 0; i < 4; i++) addrs[i] = rand_bits(10);
        a_cyc = 1;
        a_stb = 1;
        a_we  = 0;
        a_adr = addrs[0];
        for (int k = 0; k <= 4; k++) begin
            @(posedge clk);
            if (k > 0) begin
                check_val("a_ack_o", 1, a_ack);
                check_val("a_dat_o", model[addrs[k-1]], a_rdat);
            end
            #1;
            if (k < 3) a_adr = addrs[k+1];
            else a_stb = 0;
        end
        a_cyc = 0;

        // 3. Host B traffic with the DMA idle
        repeat (12) begin
            adr = rand_bits(10);
            dat = rand_bits(32);
            sel = rand_bits(4);
            b_access(1'b1, sel, adr, dat, rd, stalls);
            model[adr] = merge_bytes(model[adr], dat, sel);
            b_access(1'b0, 4'hf, adr, 32'h0, rd, stalls);
            check_val("b_dat_o", model[adr], rd);
            check_val("b_stall_cycles", 0, stalls);
        end

        // 4. Block copy between disjoint regions
        src = rand_bits(10);
        dst = src + 10'd32 + rand_bits(9);
        len = rand_bits(4) + 1;
        launch_copy(src, dst, len);
        copies++;
        for (int i = 0; i < len; i++) model[dst + i[9:0]] = model[src + i[9:0]];
        wait_copy(copies, cycles);
        check_block(dst, len);

        // 5. Host B read while the copy holds port B
        src = rand_bits(10);
        dst = src + 10'd32 + rand_bits(9);
        len = rand_bits(4) + 1;
        adr = src + 10'd600; // Outside both regions
        launch_copy(src, dst, len);
        copies++;
        for (int i = 0; i < len; i++) model[dst + i[9:0]] = model[src + i[9:0]];
        @(posedge clk); // Copy owns port B before host B asks
        #1;
        check_val("arb_owner_o", wbmem_pkg::OWN_DMA, arb_owner);
        b_access(1'b0, 4'hf, adr, 32'h0, rd, stalls);
        check_val("b_dat_o", model[adr], rd);
        assert (stalls > 0) else begin
            $display("Host B was not stalled while the DMA owned port B");
            errors++;
        end
        wait_copy(copies, cycles);
        check_block(dst, len);

        // 6. Zero length copy, done two cycles after start
        src = rand_bits(10);
        dst = src + 10'd32 + rand_bits(9);
        launch_copy(src, dst, 11'd0);
        copies++;
        wait_copy(copies, cycles);
        check_val("dma_done_cycles", 2, cycles);
        check_block(src, 4);
        check_block(dst, 4); // Untouched
        check_val("dma_done_count", copies, done_count); // No stray pulse since

        $display("Errors: %0d, timeouts: %0d, DMA copies: %0d", errors, timeouts, copies);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
